//--- Makefile
TOP := processor_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+src
src/pipe_pkg.sv
src/control_unit.sv
src/register_file.sv
src/forwarding_unit.sv
src/alu.sv
src/processor.sv
verif/clock_gen.sv
verif/processor_checker.sv
verif/processor_tb.sv

//--- src/alu.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module alu import pipe_pkg::*; (
  input  alu_op_t                alu_op,
  input  logic [`DATA_WIDTH-1:0] data1,
  input  logic [`DATA_WIDTH-1:0] data2,
  input  logic [`SHAMT_BITS-1:0] shamt,
  output logic [`DATA_WIDTH-1:0] alu_result
);

  always_comb begin
    case (alu_op)
      // add and sub wrap
      ALU_ADD: alu_result = data1 + data2;
      ALU_SUB: alu_result = data1 - data2;
      ALU_AND: alu_result = data1 & data2;
      ALU_OR:  alu_result = data1 | data2;
      ALU_XOR: alu_result = data1 ^ data2;
      // shift source is rt, not rs
      ALU_SLL: alu_result = data2 << shamt;
      default: alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit import pipe_pkg::*; (
  input  opcode_t opcode,
  output alu_op_t alu_op,
  output logic    alu_src,
  output logic    reg_dst,
  output logic    reg_write
);

  always_comb begin
    // safe defaults, no write
    alu_op    = ALU_ADD;
    alu_src   = 1'b0;
    reg_dst   = 1'b1;
    reg_write = 1'b0;
    case (opcode)
      OP_ADD: begin
        alu_op    = ALU_ADD;
        reg_write = 1'b1;
      end
      OP_SUB: begin
        alu_op    = ALU_SUB;
        reg_write = 1'b1;
      end
      OP_AND: begin
        alu_op    = ALU_AND;
        reg_write = 1'b1;
      end
      OP_OR: begin
        alu_op    = ALU_OR;
        reg_write = 1'b1;
      end
      OP_XOR: begin
        alu_op    = ALU_XOR;
        reg_write = 1'b1;
      end
      OP_SLL: begin
        alu_op    = ALU_SLL;
        reg_write = 1'b1;
      end
      // immediate forms write rt
      OP_ADDI: begin
        alu_op    = ALU_ADD;
        alu_src   = 1'b1;
        reg_dst   = 1'b0;
        reg_write = 1'b1;
      end
      OP_ORI: begin
        alu_op    = ALU_OR;
        alu_src   = 1'b1;
        reg_dst   = 1'b0;
        reg_write = 1'b1;
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/forwarding_unit.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module forwarding_unit import pipe_pkg::*; (
  input  logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rs,
  input  logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rt,
  input  logic [`DATA_WIDTH-1:0]         reg_data_1,
  input  logic [`DATA_WIDTH-1:0]         reg_data_2,
  input  logic [`NUM_REGISTERS_LOG2-1:0] ex_mem_rd,
  input  logic                           ex_mem_reg_write,
  input  logic [`DATA_WIDTH-1:0]         ex_mem_result,
  input  logic [`NUM_REGISTERS_LOG2-1:0] mem_wb_rd,
  input  logic                           mem_wb_reg_write,
  input  logic [`DATA_WIDTH-1:0]         mem_wb_result,
  output logic [`DATA_WIDTH-1:0]         operand_a,
  output logic [`DATA_WIDTH-1:0]         operand_b
);

  fwd_sel_t forward_a;
  fwd_sel_t forward_b;

  // younger producer first
  function automatic fwd_sel_t select_source(input logic [`NUM_REGISTERS_LOG2-1:0] src);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (mem_wb_reg_write && (mem_wb_rd != '0) && (mem_wb_rd == src)) begin
      sel = FWD_MEM_WB;
    end
    if (ex_mem_reg_write && (ex_mem_rd != '0) && (ex_mem_rd == src)) begin
      sel = FWD_EX_MEM;
    end
    return sel;
  endfunction

  always_comb begin
    forward_a = select_source(id_ex_rs);
    forward_b = select_source(id_ex_rt);
    case (forward_a)
      FWD_EX_MEM: operand_a = ex_mem_result;
      FWD_MEM_WB: operand_a = mem_wb_result;
      default:    operand_a = reg_data_1;
    endcase
    case (forward_b)
      FWD_EX_MEM: operand_b = ex_mem_result;
      FWD_MEM_WB: operand_b = mem_wb_result;
      default:    operand_b = reg_data_2;
    endcase
  end

endmodule

`default_nettype wire

//--- src/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

`default_nettype none

`define DATA_WIDTH          32
`define INST_WIDTH          32
`define NUM_REGISTERS       32
`define NUM_REGISTERS_LOG2  5
`define IMM_WIDTH           16
`define SHAMT_BITS          5

// instruction field positions
`define OPCODE_MSB  31
`define OPCODE_LSB  26
`define REG_RS_MSB  25
`define REG_RS_LSB  21
`define REG_RT_MSB  20
`define REG_RT_LSB  16
`define REG_RD_MSB  15
`define REG_RD_LSB  11
`define SHAMT_MSB   10
`define SHAMT_LSB   6
`define IMM_MSB     15
`define IMM_LSB     0

`default_nettype wire

`endif

//--- src/pipe_pkg.sv
`include "pipe_params.svh"
`default_nettype none

package pipe_pkg;

  // opcode values outside this list decode as no-ops
  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SLL  = 6'h06,
    OP_ADDI = 6'h08,
    OP_ORI  = 6'h0d
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5
  } alu_op_t;

  // operand source picked by the forwarding logic
  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_t;

endpackage

`default_nettype wire

//--- src/processor.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module processor import pipe_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           inst_valid,
  input  logic [`INST_WIDTH-1:0]         instruction,
  output logic                           wb_valid,
  output logic [`NUM_REGISTERS_LOG2-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]         wb_data
);

  // if/id
  logic                           if_id_valid;
  logic [`INST_WIDTH-1:0]         if_id_instruction;

  // decode
  opcode_t                        opcode;
  logic [`NUM_REGISTERS_LOG2-1:0] rs, rt, rd;
  logic [`SHAMT_BITS-1:0]         shamt;
  logic [`IMM_WIDTH-1:0]          immediate;
  alu_op_t                        alu_op;
  logic                           alu_src, reg_dst, reg_write;
  logic [`DATA_WIDTH-1:0]         reg_read_data_1, reg_read_data_2;

  // id/ex
  logic                           id_ex_valid;
  logic                           id_ex_reg_write;
  alu_op_t                        id_ex_alu_op;
  logic                           id_ex_alu_src, id_ex_reg_dst;
  logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rs, id_ex_rt, id_ex_rd;
  logic [`SHAMT_BITS-1:0]         id_ex_shamt;
  logic [`IMM_WIDTH-1:0]          id_ex_immediate;
  logic [`DATA_WIDTH-1:0]         id_ex_read_data_1, id_ex_read_data_2;

  // execute
  logic [`DATA_WIDTH-1:0]         operand_a, operand_b, alu_data2, alu_result;
  logic [`NUM_REGISTERS_LOG2-1:0] ex_dst;
  logic                           ex_reg_write;

  // ex/mem and mem/wb
  logic                           ex_mem_reg_write, mem_wb_reg_write;
  logic [`NUM_REGISTERS_LOG2-1:0] ex_mem_rd, mem_wb_rd;
  logic [`DATA_WIDTH-1:0]         ex_mem_result, mem_wb_result;

  ////////////////////////////////////////////////////////////////////////////
  // fetch and decode

  assign opcode    = opcode_t'(if_id_instruction[`OPCODE_MSB:`OPCODE_LSB]);
  assign rs        = if_id_instruction[`REG_RS_MSB:`REG_RS_LSB];
  assign rt        = if_id_instruction[`REG_RT_MSB:`REG_RT_LSB];
  assign rd        = if_id_instruction[`REG_RD_MSB:`REG_RD_LSB];
  assign shamt     = if_id_instruction[`SHAMT_MSB:`SHAMT_LSB];
  assign immediate = if_id_instruction[`IMM_MSB:`IMM_LSB];

  control_unit control_unit_i (
    .opcode    (opcode),
    .alu_op    (alu_op),
    .alu_src   (alu_src),
    .reg_dst   (reg_dst),
    .reg_write (reg_write)
  );

  register_file register_file_i (
    .clk            (clk),
    .reset          (reset),
    .read_address_1 (rs),
    .read_address_2 (rt),
    .read_data_1    (reg_read_data_1),
    .read_data_2    (reg_read_data_2),
    .write          (mem_wb_reg_write),
    .write_address  (mem_wb_rd),
    .write_data     (mem_wb_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pipeline registers

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_valid      <= 1'b0;
      id_ex_valid      <= 1'b0;
      id_ex_reg_write  <= 1'b0;
      ex_mem_reg_write <= 1'b0;
      mem_wb_reg_write <= 1'b0;
    end else begin
      if_id_valid      <= inst_valid;
      id_ex_valid      <= if_id_valid;
      id_ex_reg_write  <= reg_write;
      ex_mem_reg_write <= ex_reg_write;
      mem_wb_reg_write <= ex_mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if_id_instruction <= instruction;
    id_ex_alu_op      <= alu_op;
    id_ex_alu_src     <= alu_src;
    id_ex_reg_dst     <= reg_dst;
    id_ex_rs          <= rs;
    id_ex_rt          <= rt;
    id_ex_rd          <= rd;
    id_ex_shamt       <= shamt;
    id_ex_immediate   <= immediate;
    id_ex_read_data_1 <= reg_read_data_1;
    id_ex_read_data_2 <= reg_read_data_2;
    ex_mem_rd         <= ex_dst;
    ex_mem_result     <= alu_result;
    mem_wb_rd         <= ex_mem_rd;
    mem_wb_result     <= ex_mem_result;
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute

  forwarding_unit forwarding_unit_i (
    .id_ex_rs         (id_ex_rs),
    .id_ex_rt         (id_ex_rt),
    .reg_data_1       (id_ex_read_data_1),
    .reg_data_2       (id_ex_read_data_2),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_reg_write (ex_mem_reg_write),
    .ex_mem_result    (ex_mem_result),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_reg_write (mem_wb_reg_write),
    .mem_wb_result    (mem_wb_result),
    .operand_a        (operand_a),
    .operand_b        (operand_b)
  );

  // zero-extended immediate
  assign alu_data2 = id_ex_alu_src ?
                     {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, id_ex_immediate} : operand_b;

  alu alu_i (
    .alu_op     (id_ex_alu_op),
    .data1      (operand_a),
    .data2      (alu_data2),
    .shamt      (id_ex_shamt),
    .alu_result (alu_result)
  );

  assign ex_dst = id_ex_reg_dst ? id_ex_rd : id_ex_rt;

  // writes to r0 die here and never forward
  assign ex_reg_write = id_ex_valid && id_ex_reg_write && (ex_dst != '0);

  assign wb_valid = mem_wb_reg_write;
  assign wb_reg   = mem_wb_rd;
  assign wb_data  = mem_wb_result;

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module register_file (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [`NUM_REGISTERS_LOG2-1:0] read_address_1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] read_address_2,
  output logic [`DATA_WIDTH-1:0]         read_data_1,
  output logic [`DATA_WIDTH-1:0]         read_data_2,
  input  logic                           write,
  input  logic [`NUM_REGISTERS_LOG2-1:0] write_address,
  input  logic [`DATA_WIDTH-1:0]         write_data
);

  logic [`DATA_WIDTH-1:0] registers [`NUM_REGISTERS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGISTERS; i++) begin
        registers[i] <= '0;
      end
    end else if (write && (write_address != '0)) begin
      registers[write_address] <= write_data;
    end
  end

  // r0 is hardwired, a same-cycle write wins over the array
  assign read_data_1 = (read_address_1 == '0) ? '0 :
                       (write && (write_address == read_address_1)) ? write_data :
                       registers[read_address_1];

  assign read_data_2 = (read_address_2 == '0) ? '0 :
                       (write && (write_address == read_address_2)) ? write_data :
                       registers[read_address_2];

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/processor_checker.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module processor_checker (
  input logic                           clk,
  input logic                           reset,
  input logic                           inst_valid,
  input logic                           wb_valid,
  input logic [`NUM_REGISTERS_LOG2-1:0] wb_reg
);

  logic [2:0] cycles_since_reset;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycles_since_reset <= 3'd0;
    end else if (cycles_since_reset != 3'd4) begin
      cycles_since_reset <= cycles_since_reset + 3'd1;
    end
  end

  quiet_in_reset: assert property (@(posedge clk) reset |=> !wb_valid)
    else $error("write-back seen while in reset");

  quiet_after_reset: assert property (@(posedge clk)
    (!reset && (cycles_since_reset < 3'd4)) |-> !wb_valid)
    else $error("write-back seen before the pipe could fill");

  no_r0_write: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_reg != '0))
    else $error("write-back to register 0");

  // four pipeline registers between issue and retire
  fixed_latency: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(inst_valid, 4))
    else $error("write-back without an instruction four cycles earlier");

endmodule

bind processor processor_checker processor_checker_i (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .wb_valid   (wb_valid),
  .wb_reg     (wb_reg)
);

`default_nettype wire

//--- verif/processor_tb.sv
`timescale 1ns/10ps
`include "pipe_params.svh"
`default_nettype none

module processor_tb import pipe_pkg::*; ();

  localparam int DRAIN_TIMEOUT = 100;

  logic                           clk, reset, inst_valid;
  logic [`INST_WIDTH-1:0]         instruction;
  logic                           wb_valid;
  logic [`NUM_REGISTERS_LOG2-1:0] wb_reg;
  logic [`DATA_WIDTH-1:0]         wb_data;

  // reference model state
  logic [`DATA_WIDTH-1:0]         model_regs [`NUM_REGISTERS];
  logic [`NUM_REGISTERS_LOG2-1:0] exp_reg_q [$];
  logic [`DATA_WIDTH-1:0]         exp_data_q [$];
  int errors, checks, tests_run, tests_failed, errors_at_start;

  opcode_t    r_ops   [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
  logic [5:0] bad_ops [7] = '{6'h07, 6'h09, 6'h0c, 6'h10, 6'h23, 6'h2b, 6'h3f};
  logic [5:0] all_ops [9] = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                              OP_SLL, OP_ADDI, OP_ORI};

  clock_gen clock_gen_i (.clk(clk), .reset(reset));

  processor processor_i (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .instruction (instruction),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  function automatic logic [31:0] r_type(input opcode_t op, input logic [4:0] rs, rt, rd, sh);
    return {op, rs, rt, rd, sh, 6'b0};
  endfunction

  function automatic logic [31:0] i_type(input opcode_t op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic void apply_model(input logic [31:0] inst);
    opcode_t     op;
    logic [4:0]  rs, rt, dst;
    logic [31:0] a, b, imm, res;
    logic        wr;
    op  = opcode_t'(inst[`OPCODE_MSB:`OPCODE_LSB]);
    rs  = inst[`REG_RS_MSB:`REG_RS_LSB];
    rt  = inst[`REG_RT_MSB:`REG_RT_LSB];
    dst = inst[`REG_RD_MSB:`REG_RD_LSB];
    a   = model_regs[rs];
    b   = model_regs[rt];
    imm = {16'h0, inst[`IMM_MSB:`IMM_LSB]};
    wr  = 1'b1;
    res = '0;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLL:  res = b << inst[`SHAMT_MSB:`SHAMT_LSB];
      OP_ADDI: begin
        res = a + imm;
        dst = rt;
      end
      OP_ORI: begin
        res = a | imm;
        dst = rt;
      end
      default: wr = 1'b0;
    endcase
    // r0 stays zero and never retires
    if (wr && (dst != 5'd0)) begin
      model_regs[dst] = res;
      exp_reg_q.push_back(dst);
      exp_data_q.push_back(res);
    end
  endfunction

  task automatic issue(input logic [31:0] inst);
    @(negedge clk);
    inst_valid  = 1'b1;
    instruction = inst;
    apply_model(inst);
  endtask

  // junk on the bus while not valid
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      inst_valid  = 1'b0;
      instruction = $urandom();
    end
  endtask

  task automatic finish_test(input string name);
    int cycles;
    cycles = 0;
    idle(1);
    while ((exp_reg_q.size() != 0) && (cycles < DRAIN_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    idle(5);
    if (exp_reg_q.size() != 0) begin
      errors++;
      $display("%s did not finish, %0d write-backs never arrived", name, exp_reg_q.size());
      exp_reg_q.delete();
      exp_data_q.delete();
    end
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_at_start);
    end else begin
      $display("%s: ok", name);
    end
    errors_at_start = errors;
  endtask

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(7, 0));
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [31:0] inst;
    inst = $urandom();
    inst[`OPCODE_MSB:`OPCODE_LSB] = ($urandom_range(15, 0) == 0) ?
                                    bad_ops[$urandom_range(6, 0)] : all_ops[$urandom_range(8, 0)];
    inst[`REG_RS_MSB:`REG_RS_LSB] = rand_reg();
    inst[`REG_RT_MSB:`REG_RT_LSB] = rand_reg();
    inst[`REG_RD_MSB:`REG_RD_LSB] = rand_reg();
    return inst;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // write-back monitor, sampled mid-cycle

  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (exp_reg_q.size() == 0) begin
        errors++;
        $display("unexpected write-back to register %0d with nothing pending", wb_reg);
      end else begin
        check_value("wb_reg", 32'(wb_reg), 32'(exp_reg_q.pop_front()));
        check_value("wb_data", wb_data, exp_data_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  initial begin
    int         cycles;
    logic [4:0] prev, dst, other;
    opcode_t    op;
    void'($urandom(32'h9427_fe83));
    inst_valid  = 1'b0;
    instruction = '0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_at_start = 0;
    for (int i = 0; i < `NUM_REGISTERS; i++) begin
      model_regs[i] = '0;
    end
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while ((reset !== 1'b0) && (cycles < 20));
    if (reset !== 1'b0) begin
      errors++;
      $display("reset never went low");
    end

    // nothing retires before the first instruction
    idle(8);
    // each register is read before anything writes it
    for (int i = 1; i < 32; i++) begin
      issue(r_type(OP_ADD, 5'd0, 5'(i), 5'(i), 5'd0));
    end
    finish_test("test 1 reset state");

    // ffff0000 | ffff then +1 wraps to zero
    issue(i_type(OP_ORI, 5'd0, 5'd1, 16'hffff));
    idle(3);
    issue(r_type(OP_SLL, 5'd0, 5'd1, 5'd2, 5'd16));
    idle(3);
    issue(i_type(OP_ORI, 5'd2, 5'd3, 16'hffff));
    idle(3);
    issue(i_type(OP_ADDI, 5'd3, 5'd4, 16'h0001));
    idle(3);
    for (int n = 0; n < 60; n++) begin
      case ($urandom % 3)
        0:       issue(i_type(OP_ADDI, rand_reg(), rand_reg(), 16'($urandom())));
        1:       issue(i_type(OP_ORI, rand_reg(), rand_reg(), 16'($urandom())));
        default: issue(r_type(OP_SLL, rand_reg(), rand_reg(), rand_reg(), 5'($urandom())));
      endcase
      idle(3);
    end
    finish_test("test 2 immediates and shifts");

    // gap 0 hits ex/mem, 1 hits mem/wb, 2 hits the register file bypass
    for (int gap = 0; gap < 3; gap++) begin
      for (int chain = 0; chain < 8; chain++) begin
        prev = 5'($urandom_range(31, 1));
        issue(i_type(OP_ORI, 5'd0, prev, 16'($urandom())));
        idle(gap);
        for (int k = 0; k < 6; k++) begin
          dst   = 5'($urandom_range(31, 1));
          other = 5'($urandom());
          op    = r_ops[$urandom_range(4, 0)];
          if ($urandom_range(1, 0) == 1) begin
            issue(r_type(op, prev, other, dst, 5'd0));
          end else begin
            issue(r_type(op, other, prev, dst, 5'd0));
          end
          idle(gap);
          prev = dst;
        end
      end
    end
    finish_test("test 3 forwarding chains");

    issue(32'h0);
    for (int i = 0; i < 8; i++) begin
      issue({bad_ops[$urandom_range(6, 0)], 26'($urandom())});
    end
    issue(r_type(OP_ADD, 5'd1, 5'd2, 5'd0, 5'd0));
    issue(i_type(OP_ORI, 5'd0, 5'd0, 16'h1234));
    issue(r_type(OP_SLL, 5'd0, 5'd3, 5'd0, 5'd4));
    issue(i_type(OP_ADDI, 5'd4, 5'd0, 16'hbeef));
    // readers of r0 right behind the suppressed writes
    issue(r_type(OP_OR, 5'd0, 5'd0, 5'd5, 5'd0));
    issue(i_type(OP_ADDI, 5'd0, 5'd6, 16'h0042));
    finish_test("test 4 no-ops and register 0");

    for (int n = 0; n < 2000; n++) begin
      issue(rand_inst());
      if ($urandom_range(3, 0) == 0) begin
        idle($urandom_range(3, 1));
      end
    end
    finish_test("test 5 random mix");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
